// ==== hdl/core_pkg.sv ====
// ====================================================================
// Core package
// Widths, opcodes, ALU operations, stage indices and the pipeline
// payload types shared by the five-stage integer core
// ====================================================================
package core_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_stages = 5;

    localparam logic [data_w-1:0] reset_pc = '0;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_lui, alu_pass
    } alu_op_t;

    // Indices into the stall vector, fetch first
    typedef enum logic [2:0] {
        stg_if, stg_id, stg_ex, stg_mem, stg_wb
    } stage_e;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_inst_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } i_inst_t;

    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

    typedef struct packed {
        logic [data_w-1:0]     pc;
        alu_op_t               alu_op;
        logic [data_w-1:0]     opr1;
        logic [data_w-1:0]     opr2;
        logic [data_w-1:0]     st_data;
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic                  mem_en;
        logic                  mem_wr;
    } id_ex_t;

    typedef struct packed {
        logic [data_w-1:0]     alu_res;
        logic [data_w-1:0]     st_data;
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic                  mem_en;
        logic                  mem_wr;
    } ex_mem_t;

endpackage

// ==== hdl/pipe_ctrl_if.sv ====
// ====================================================================
// Pipeline control interface
// Stall requests from the stages and the per-stage stall vector
// ====================================================================
`timescale 1ns/1ps

interface pipe_ctrl_if;

    logic streq_if;
    logic streq_id;
    logic streq_mem;
    logic load_in_ex;     // Execute holds a load whose data is not back yet

    logic [core_pkg::num_stages-1:0] stall;

    modport stage (
        output streq_if,
        output streq_id,
        output streq_mem,
        output load_in_ex,
        input  stall
    );

    modport ctrl (
        input  streq_if,
        input  streq_id,
        input  streq_mem,
        output stall
    );

endinterface

// ==== hdl/fetch_unit.sv ====
// ====================================================================
// Fetch unit
// Program counter, instruction bus drive and the IF/ID register
// ====================================================================
`timescale 1ns/1ps

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n_i,
    pipe_ctrl_if.stage                  ctl,
    input  logic                        br_flag_i,
    input  logic [core_pkg::data_w-1:0] br_addr_i,
    output logic                        ibus_en_o,
    output logic [core_pkg::data_w-1:0] ibus_addr_o,
    input  logic [core_pkg::data_w-1:0] ibus_rdata_i,
    input  logic                        ibus_streq_i,
    output logic [core_pkg::data_w-1:0] if_pc_o,
    output core_pkg::inst_u             if_inst_o
);

    logic [core_pkg::data_w-1:0] pc_q;
    logic [core_pkg::data_w-1:0] pc_next;
    logic [core_pkg::data_w-1:0] br_pend_addr_q;
    logic                        br_pend_q;
    logic                        fetch_on_q;
    logic                        stall_if;

    assign stall_if     = ctl.stall[core_pkg::stg_if];
    assign ibus_en_o    = fetch_on_q;
    assign ibus_addr_o  = pc_q;
    assign ctl.streq_if = fetch_on_q & ibus_streq_i;

    always_comb begin
        if (br_flag_i) begin
            pc_next = br_addr_i;
        end else if (br_pend_q) begin
            pc_next = br_pend_addr_q;     // Branch left decode while fetch waited
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= core_pkg::reset_pc;
            fetch_on_q <= 1'b0;
            br_pend_q  <= 1'b0;
        end else begin
            fetch_on_q <= 1'b1;
            if (fetch_on_q && !stall_if) begin
                pc_q      <= pc_next;
                br_pend_q <= 1'b0;
            end else if (br_flag_i && !ctl.stall[core_pkg::stg_id]) begin
                br_pend_q      <= 1'b1;
                br_pend_addr_q <= br_addr_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            if_inst_o <= '0;
        end else if (!ctl.stall[core_pkg::stg_id]) begin
            if_pc_o   <= pc_q;
            if_inst_o <= (stall_if || !fetch_on_q) ? '0 : ibus_rdata_i;
        end
    end

endmodule

// ==== hdl/decode_unit.sv ====
// ====================================================================
// Decode unit
// Instruction decode, register file with forwarding, load-use
// detection, branch resolution and the ID/EX register
// ====================================================================
`timescale 1ns/1ps

module decode_unit (
    input  logic                            clk,
    input  logic                            rst_n_i,
    pipe_ctrl_if.stage                      ctl,
    input  logic [core_pkg::data_w-1:0]     if_pc_i,
    input  core_pkg::inst_u                 if_inst_i,
    input  logic                            wb_we_i,
    input  logic [core_pkg::reg_addr_w-1:0] wb_waddr_i,
    input  logic [core_pkg::data_w-1:0]     wb_wdata_i,
    input  logic                            ex_fwd_we_i,
    input  logic [core_pkg::reg_addr_w-1:0] ex_fwd_addr_i,
    input  logic [core_pkg::data_w-1:0]     ex_fwd_data_i,
    input  logic                            mem_fwd_we_i,
    input  logic [core_pkg::reg_addr_w-1:0] mem_fwd_addr_i,
    input  logic [core_pkg::data_w-1:0]     mem_fwd_data_i,
    output logic                            br_flag_o,
    output logic [core_pkg::data_w-1:0]     br_addr_o,
    output core_pkg::id_ex_t                id_ex_o
);

    logic [core_pkg::data_w-1:0] rf [32];
    logic [core_pkg::data_w-1:0] rs_val;
    logic [core_pkg::data_w-1:0] rt_val;
    logic [core_pkg::data_w-1:0] imm_sext;
    logic [core_pkg::data_w-1:0] imm_zext;
    logic [5:0]                  opcode;
    logic                        uses_rt;
    logic                        is_branch;
    core_pkg::id_ex_t            id_ex_d;

    // Youngest producer wins, register zero is hard-wired
    function automatic logic [core_pkg::data_w-1:0] read_src(
        input logic [core_pkg::reg_addr_w-1:0] a
    );
        logic [core_pkg::data_w-1:0] v;
        if (a == '0) v = '0;
        else if (ex_fwd_we_i && ex_fwd_addr_i == a) v = ex_fwd_data_i;
        else if (mem_fwd_we_i && mem_fwd_addr_i == a) v = mem_fwd_data_i;
        else if (wb_we_i && wb_waddr_i == a) v = wb_wdata_i;
        else v = rf[a];
        return v;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we_i) begin
            rf[wb_waddr_i] <= wb_wdata_i;
        end
    end

    assign opcode   = if_inst_i.i.opcode;
    assign imm_sext = {{16{if_inst_i.i.imm[15]}}, if_inst_i.i.imm};
    assign imm_zext = {16'h0, if_inst_i.i.imm};

    always_comb begin
        rs_val = read_src(if_inst_i.i.rs);
        rt_val = read_src(if_inst_i.i.rt);
    end

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.pc      = if_pc_i;
        id_ex_d.alu_op  = core_pkg::alu_pass;
        id_ex_d.opr1    = rs_val;
        id_ex_d.opr2    = imm_sext;
        id_ex_d.st_data = rt_val;
        id_ex_d.waddr   = if_inst_i.i.rt;
        uses_rt         = 1'b0;
        case (opcode)
            core_pkg::op_special: begin
                uses_rt       = 1'b1;
                id_ex_d.opr2  = rt_val;
                id_ex_d.waddr = if_inst_i.r.rd;
                id_ex_d.we    = 1'b1;
                case (if_inst_i.r.funct)
                    core_pkg::fn_addu: id_ex_d.alu_op = core_pkg::alu_add;
                    core_pkg::fn_subu: id_ex_d.alu_op = core_pkg::alu_sub;
                    core_pkg::fn_and:  id_ex_d.alu_op = core_pkg::alu_and;
                    core_pkg::fn_or:   id_ex_d.alu_op = core_pkg::alu_or;
                    core_pkg::fn_xor:  id_ex_d.alu_op = core_pkg::alu_xor;
                    core_pkg::fn_slt:  id_ex_d.alu_op = core_pkg::alu_slt;
                    default:           id_ex_d.we     = 1'b0;   // Retires as a no-op
                endcase
            end
            core_pkg::op_addiu: begin
                id_ex_d.alu_op = core_pkg::alu_add;
                id_ex_d.we     = 1'b1;
            end
            core_pkg::op_ori, core_pkg::op_lui: begin
                id_ex_d.alu_op = (opcode == core_pkg::op_lui) ? core_pkg::alu_lui
                                                               : core_pkg::alu_or;
                id_ex_d.opr2   = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            core_pkg::op_lw: begin
                id_ex_d.alu_op = core_pkg::alu_add;
                id_ex_d.we     = 1'b1;
                id_ex_d.mem_en = 1'b1;
            end
            core_pkg::op_sw: begin
                uses_rt        = 1'b1;
                id_ex_d.alu_op = core_pkg::alu_add;
                id_ex_d.mem_en = 1'b1;
                id_ex_d.mem_wr = 1'b1;
            end
            core_pkg::op_beq, core_pkg::op_bne: uses_rt = 1'b1;
            default: ;
        endcase
    end

    assign ctl.streq_id = ctl.load_in_ex && ex_fwd_we_i && ex_fwd_addr_i != '0 &&
                          (ex_fwd_addr_i == if_inst_i.i.rs ||
                           (uses_rt && ex_fwd_addr_i == if_inst_i.i.rt));

    assign is_branch = opcode == core_pkg::op_beq || opcode == core_pkg::op_bne;
    assign br_flag_o = is_branch && ((rs_val == rt_val) ^ (opcode == core_pkg::op_bne));
    assign br_addr_o = if_pc_i + 32'd4 + {imm_sext[29:0], 2'b00};   // From the delay slot

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else if (!ctl.stall[core_pkg::stg_ex]) begin
            id_ex_o        <= id_ex_d;
            id_ex_o.we     <= id_ex_d.we & ~ctl.stall[core_pkg::stg_id];
            id_ex_o.mem_en <= id_ex_d.mem_en & ~ctl.stall[core_pkg::stg_id];
        end
    end

endmodule

// ==== hdl/execute_unit.sv ====
// ====================================================================
// Execute unit
// ALU, load and store address generation and the EX/MEM register
// ====================================================================
`timescale 1ns/1ps

module execute_unit (
    input  logic                            clk,
    input  logic                            rst_n_i,
    pipe_ctrl_if.stage                      ctl,
    input  core_pkg::id_ex_t                id_ex_i,
    output logic                            ex_fwd_we_o,
    output logic [core_pkg::reg_addr_w-1:0] ex_fwd_addr_o,
    output logic [core_pkg::data_w-1:0]     ex_fwd_data_o,
    output core_pkg::ex_mem_t               ex_mem_o
);

    logic [core_pkg::data_w-1:0] alu_res;
    logic                        bubble;

    always_comb begin
        case (id_ex_i.alu_op)
            core_pkg::alu_add:  alu_res = id_ex_i.opr1 + id_ex_i.opr2;  // Also load and store
            core_pkg::alu_sub:  alu_res = id_ex_i.opr1 - id_ex_i.opr2;
            core_pkg::alu_and:  alu_res = id_ex_i.opr1 & id_ex_i.opr2;
            core_pkg::alu_or:   alu_res = id_ex_i.opr1 | id_ex_i.opr2;
            core_pkg::alu_xor:  alu_res = id_ex_i.opr1 ^ id_ex_i.opr2;
            core_pkg::alu_slt:  alu_res = {31'h0, $signed(id_ex_i.opr1) < $signed(id_ex_i.opr2)};
            core_pkg::alu_lui:  alu_res = {id_ex_i.opr2[15:0], 16'h0};
            core_pkg::alu_pass: alu_res = id_ex_i.opr1;
            default:            alu_res = id_ex_i.opr1;
        endcase
    end

    assign ctl.load_in_ex = id_ex_i.mem_en & ~id_ex_i.mem_wr;

    assign ex_fwd_we_o   = id_ex_i.we;
    assign ex_fwd_addr_o = id_ex_i.waddr;
    assign ex_fwd_data_o = alu_res;

    assign bubble = ctl.stall[core_pkg::stg_ex];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_o <= '0;
        end else if (!ctl.stall[core_pkg::stg_mem]) begin
            ex_mem_o.alu_res <= alu_res;
            ex_mem_o.st_data <= id_ex_i.st_data;
            ex_mem_o.we      <= id_ex_i.we & ~bubble;
            ex_mem_o.waddr   <= id_ex_i.waddr;
            ex_mem_o.mem_en  <= id_ex_i.mem_en & ~bubble;
            ex_mem_o.mem_wr  <= id_ex_i.mem_wr;
        end
    end

endmodule

// ==== hdl/mem_access.sv ====
// ====================================================================
// Memory access unit
// Data bus drive, load capture and the MEM/WB register that feeds
// the register file write port
// ====================================================================
`timescale 1ns/1ps

module mem_access (
    input  logic                            clk,
    input  logic                            rst_n_i,
    pipe_ctrl_if.stage                      ctl,
    input  core_pkg::ex_mem_t               ex_mem_i,
    output logic                            dbus_en_o,
    output logic [core_pkg::data_w-1:0]     dbus_addr_o,
    output logic [3:0]                      dbus_wen_o,
    output logic [core_pkg::data_w-1:0]     dbus_wdata_o,
    input  logic [core_pkg::data_w-1:0]     dbus_rdata_i,
    input  logic                            dbus_streq_i,
    output logic                            mem_fwd_we_o,
    output logic [core_pkg::reg_addr_w-1:0] mem_fwd_addr_o,
    output logic [core_pkg::data_w-1:0]     mem_fwd_data_o,
    output logic                            wb_we_o,
    output logic [core_pkg::reg_addr_w-1:0] wb_waddr_o,
    output logic [core_pkg::data_w-1:0]     wb_wdata_o
);

    logic is_load;

    assign dbus_en_o     = ex_mem_i.mem_en;
    assign dbus_addr_o   = ex_mem_i.alu_res;
    assign dbus_wen_o    = {4{ex_mem_i.mem_en & ex_mem_i.mem_wr}};   // Word stores only
    assign dbus_wdata_o  = ex_mem_i.st_data;
    assign ctl.streq_mem = ex_mem_i.mem_en & dbus_streq_i;

    assign is_load        = ex_mem_i.mem_en & ~ex_mem_i.mem_wr;
    assign mem_fwd_we_o   = ex_mem_i.we;
    assign mem_fwd_addr_o = ex_mem_i.waddr;
    assign mem_fwd_data_o = is_load ? dbus_rdata_i : ex_mem_i.alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
        end else if (!ctl.stall[core_pkg::stg_wb]) begin
            wb_we_o    <= ex_mem_i.we & ~ctl.stall[core_pkg::stg_mem];
            wb_waddr_o <= ex_mem_i.waddr;
            wb_wdata_o <= mem_fwd_data_o;
        end
    end

endmodule

// ==== hdl/pipeline_control.sv ====
// ====================================================================
// Pipeline control
// Turns stage stall requests into the per-stage stall vector
// ====================================================================
`timescale 1ns/1ps

module pipeline_control (
    pipe_ctrl_if.ctrl ctl
);

    core_pkg::stage_e req_stage;
    logic             any_req;

    always_comb begin
        any_req = ctl.streq_if | ctl.streq_id | ctl.streq_mem;
        if (ctl.streq_mem) begin
            req_stage = core_pkg::stg_mem;        // Data bus outranks everything
        end else if (ctl.streq_id) begin
            req_stage = core_pkg::stg_id;
        end else begin
            req_stage = core_pkg::stg_if;
        end
    end

    // Requesting stage and all older ones hold
    always_comb begin
        for (int s = 0; s < core_pkg::num_stages; s++) begin
            ctl.stall[s] = any_req && (s <= int'(req_stage));
        end
    end

endmodule

// ==== hdl/mango_core_top.sv ====
// ====================================================================
// Core top level
// Five-stage integer pipeline wired to the instruction and data buses
// ====================================================================
`timescale 1ns/1ps

module mango_core_top (
    input  logic        clk,
    input  logic        rst_n_i,

    output logic        ibus_en_o,
    output logic [31:0] ibus_addr_o,
    input  logic [31:0] ibus_rdata_i,
    input  logic        ibus_streq_i,

    output logic        dbus_en_o,
    output logic [31:0] dbus_addr_o,
    input  logic [31:0] dbus_rdata_i,
    output logic [3:0]  dbus_wen_o,
    output logic [31:0] dbus_wdata_o,
    input  logic        dbus_streq_i
);

    logic [core_pkg::data_w-1:0]     if_pc;
    core_pkg::inst_u                 if_inst;
    logic                            br_flag;
    logic [core_pkg::data_w-1:0]     br_addr;
    core_pkg::id_ex_t                id_ex;
    core_pkg::ex_mem_t               ex_mem;

    logic                            ex_fwd_we;
    logic [core_pkg::reg_addr_w-1:0] ex_fwd_addr;
    logic [core_pkg::data_w-1:0]     ex_fwd_data;
    logic                            mem_fwd_we;
    logic [core_pkg::reg_addr_w-1:0] mem_fwd_addr;
    logic [core_pkg::data_w-1:0]     mem_fwd_data;
    logic                            wb_we;
    logic [core_pkg::reg_addr_w-1:0] wb_waddr;
    logic [core_pkg::data_w-1:0]     wb_wdata;

    pipe_ctrl_if ctl ();

    fetch_unit u_fetch (
        .clk (clk), .rst_n_i (rst_n_i), .ctl (ctl),
        .br_flag_i    ( br_flag      ),
        .br_addr_i    ( br_addr      ),
        .ibus_en_o    ( ibus_en_o    ),
        .ibus_addr_o  ( ibus_addr_o  ),
        .ibus_rdata_i ( ibus_rdata_i ),
        .ibus_streq_i ( ibus_streq_i ),
        .if_pc_o      ( if_pc        ),
        .if_inst_o    ( if_inst      )
    );

    decode_unit u_decode (
        .clk (clk), .rst_n_i (rst_n_i), .ctl (ctl),
        .if_pc_i        ( if_pc        ),
        .if_inst_i      ( if_inst      ),
        .wb_we_i        ( wb_we        ),
        .wb_waddr_i     ( wb_waddr     ),
        .wb_wdata_i     ( wb_wdata     ),
        .ex_fwd_we_i    ( ex_fwd_we    ),
        .ex_fwd_addr_i  ( ex_fwd_addr  ),
        .ex_fwd_data_i  ( ex_fwd_data  ),
        .mem_fwd_we_i   ( mem_fwd_we   ),
        .mem_fwd_addr_i ( mem_fwd_addr ),
        .mem_fwd_data_i ( mem_fwd_data ),
        .br_flag_o      ( br_flag      ),
        .br_addr_o      ( br_addr      ),
        .id_ex_o        ( id_ex        )
    );

    execute_unit u_execute (
        .clk (clk), .rst_n_i (rst_n_i), .ctl (ctl),
        .id_ex_i        ( id_ex        ),
        .ex_fwd_we_o    ( ex_fwd_we    ),
        .ex_fwd_addr_o  ( ex_fwd_addr  ),
        .ex_fwd_data_o  ( ex_fwd_data  ),
        .ex_mem_o       ( ex_mem       )
    );

    mem_access u_mem (
        .clk (clk), .rst_n_i (rst_n_i), .ctl (ctl),
        .ex_mem_i       ( ex_mem       ),
        .dbus_en_o      ( dbus_en_o    ),
        .dbus_addr_o    ( dbus_addr_o  ),
        .dbus_wen_o     ( dbus_wen_o   ),
        .dbus_wdata_o   ( dbus_wdata_o ),
        .dbus_rdata_i   ( dbus_rdata_i ),
        .dbus_streq_i   ( dbus_streq_i ),
        .mem_fwd_we_o   ( mem_fwd_we   ),
        .mem_fwd_addr_o ( mem_fwd_addr ),
        .mem_fwd_data_o ( mem_fwd_data ),
        .wb_we_o        ( wb_we        ),
        .wb_waddr_o     ( wb_waddr     ),
        .wb_wdata_o     ( wb_wdata     )
    );

    pipeline_control u_ctrl (
        .ctl ( ctl )
    );

endmodule

// ==== tb/core_props.sv ====
// ====================================================================
// Core bus properties
// Reset quietness, data bus hold under stall, store enables and
// instruction address alignment
// ====================================================================
`timescale 1ns/1ps

module core_props (
    input logic        clk,
    input logic        rst_n_i,
    input logic        ibus_en_i,
    input logic [31:0] ibus_addr_i,
    input logic        dbus_en_i,
    input logic [31:0] dbus_addr_i,
    input logic [3:0]  dbus_wen_i,
    input logic [31:0] dbus_wdata_i,
    input logic        dbus_streq_i
);

    int fail_cnt = 0;

    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !ibus_en_i && !dbus_en_i && dbus_wen_i == 4'h0)
        else begin fail_cnt++; $error("bus enable high after a reset cycle"); end

    dbus_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        dbus_en_i && dbus_streq_i |=>
            $stable(dbus_addr_i) && $stable(dbus_wdata_i) && $stable(dbus_wen_i))
        else begin fail_cnt++; $error("data bus changed while stalled"); end

    wen_whole_word: assert property (@(posedge clk) disable iff (!rst_n_i)
        dbus_wen_i == 4'h0 || dbus_wen_i == 4'hf)
        else begin fail_cnt++; $error("partial byte enables on the data bus"); end

    ibus_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        ibus_addr_i[1:0] == 2'b00)
        else begin fail_cnt++; $error("instruction address not word aligned"); end

endmodule

// ==== tb/tb_mango_core.sv ====
// ====================================================================
// Core testbench
// Runs the programs from the test file on the core with randomly
// stalling instruction and data memories and checks the store stream
// ====================================================================
`timescale 1ns/1ps

module tb_mango_core;

    localparam int          timeout_cycles = 2000;
    localparam logic [31:0] end_addr       = 32'h0000_03fc;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic [1:0]  streq;               // Bit 0 instruction bus, bit 1 data bus
    int          hold_cnt [2];
    logic        ibus_en, dbus_en;
    logic [31:0] ibus_addr, ibus_rdata, dbus_addr, dbus_rdata, dbus_wdata;
    logic [3:0]  dbus_wen;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] prog_a[$], prog_w[$], exp_a[$], exp_d[$];
    logic [31:0] wr_addr_q[$], wr_data_q[$];
    logic        end_seen = 1'b1;
    int          test_errs, tests_run, tests_failed;

    mango_core_top dut (
        .clk (clk), .rst_n_i (rst_n_i),
        .ibus_en_o (ibus_en), .ibus_addr_o (ibus_addr),
        .ibus_rdata_i (ibus_rdata), .ibus_streq_i (streq[0]),
        .dbus_en_o (dbus_en), .dbus_addr_o (dbus_addr), .dbus_rdata_i (dbus_rdata),
        .dbus_wen_o (dbus_wen), .dbus_wdata_o (dbus_wdata), .dbus_streq_i (streq[1])
    );

    bind mango_core_top core_props u_props (
        .clk (clk), .rst_n_i (rst_n_i),
        .ibus_en_i (ibus_en_o), .ibus_addr_i (ibus_addr_o),
        .dbus_en_i (dbus_en_o), .dbus_addr_i (dbus_addr_o), .dbus_wen_i (dbus_wen_o),
        .dbus_wdata_i (dbus_wdata_o), .dbus_streq_i (dbus_streq_i)
    );

    always #20 clk = ~clk;

    // Read data is defined only in a cycle with the bus enable high
    assign ibus_rdata = ibus_en ? imem[ibus_addr[9:2]] : 32'hx;
    assign dbus_rdata = dbus_en ? dmem[dbus_addr[9:2]] : 32'hx;

    // Stalls last 1 to 3 cycles and are followed by at least one free cycle
    always @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (hold_cnt[b] != 0) begin
                hold_cnt[b] <= hold_cnt[b] - 1;
                streq[b]    <= hold_cnt[b] > 1;
            end else if ($urandom_range(3) == 0) begin
                hold_cnt[b] <= 1 + $urandom_range(2);
                streq[b]    <= 1'b1;
            end else begin
                streq[b] <= 1'b0;
            end
        end
    end

    // A write completes in a cycle with the enable high and no stall request
    always @(negedge clk) begin
        if (rst_n_i && dbus_en && !streq[1] && dbus_wen != 4'h0) begin
            dmem[dbus_addr[9:2]] = dbus_wdata;
            if (!end_seen) begin
                wr_addr_q.push_back(dbus_addr);
                wr_data_q.push_back(dbus_wdata);
                end_seen = (dbus_addr == end_addr);
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", what, got, exp);
            test_errs++;
        end
    endtask

    task automatic load_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {6'h00, 20'(i), 6'h3f};          // SPECIAL with an unknown funct
            dmem[i] = 32'ha500_0000 | (i << 2);
        end
        foreach (prog_a[k]) imem[prog_a[k][9:2]] = prog_w[k];
    endtask

    task automatic run_test(input string name);
        int cycles;
        int n;
        rst_n_i <= 1'b0;
        repeat (2) @(posedge clk);
        load_memories();
        wr_addr_q.delete();
        wr_data_q.delete();
        end_seen = 1'b0;
        rst_n_i <= 1'b1;
        cycles = 0;
        while (!end_seen && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        test_errs = 0;
        if (!end_seen) begin
            $display("test %s: no store to 0x3fc within %0d cycles", name, timeout_cycles);
            test_errs++;
        end
        if (wr_addr_q.size() != exp_a.size()) begin
            $display("test %s: %0d data writes seen but %0d expected",
                     name, wr_addr_q.size(), exp_a.size());
            test_errs++;
        end
        n = (wr_addr_q.size() < exp_a.size()) ? wr_addr_q.size() : exp_a.size();
        for (int k = 0; k < n; k++) begin
            check_value($sformatf("dbus_addr_o write %0d", k), wr_addr_q[k], exp_a[k]);
            check_value($sformatf("dbus_wdata_o write %0d", k), wr_data_q[k], exp_d[k]);
        end
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %-10s %s after %0d cycles", name, (test_errs == 0) ? "passed" : "FAILED",
                 cycles);
        prog_a.delete();
        prog_w.delete();
        exp_a.delete();
        exp_d.delete();
    endtask

    initial begin
        int          fd;
        string       line;
        string       tname;
        byte         kind;
        logic [31:0] a, v;
        logic        have_test;
        rst_n_i   = 1'b0;
        streq     = 2'b00;
        have_test = 1'b0;
        void'($urandom(68367));
        fd = $fopen("tb/core_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/core_tests.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && $sscanf(line, "%c", kind) == 1) begin
                    case (kind)
                        "t": begin
                            if (have_test) run_test(tname);
                            void'($sscanf(line, "t %s", tname));
                            have_test = 1'b1;
                        end
                        "p": if ($sscanf(line, "p %h %h", a, v) == 2) begin
                            prog_a.push_back(a);
                            prog_w.push_back(v);
                        end
                        "e": if ($sscanf(line, "e %h %h", a, v) == 2) begin
                            exp_a.push_back(a);
                            exp_d.push_back(v);
                        end
                        default: ;                      // Comments and blank lines
                    endcase
                end
            end
            if (have_test) run_test(tname);
            $fclose(fd);
            $display("tests %0d, failed %0d, assertion failures %0d",
                     tests_run, tests_failed, dut.u_props.fail_cnt);
            if (tests_run > 0 && tests_failed == 0 && dut.u_props.fail_cnt == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
hdl/core_pkg.sv
hdl/pipe_ctrl_if.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/mem_access.sv
hdl/pipeline_control.sv
hdl/mango_core_top.sv
tb/core_props.sv
tb/tb_mango_core.sv

// ==== tb/core_tests.txt ====
# t <name> starts a test, p <addr> <inst> is a program word, e <addr> <data> is an
# expected data bus write in order (hex), loads see 0xa5000000 | byte address
t alu_fwd
p 00 3c011234
p 04 34215678
p 08 2402fffd
p 0c 00221821
p 10 00612023
p 14 00612824
p 18 00a23025
p 1c 00c13826
p 20 00e1402a
p 24 24000005
p 28 ac040104
p 2c ac070110
p 30 ac080114
p 34 ac0003fc
e 104 fffffffd
e 110 edcba985
e 114 00000001
e 3fc 00000000
t load_use
p 00 8c010040
p 04 00211021
p 08 8c030044
p 0c ac030200
p 10 ac0203fc
e 200 a5000044
e 3fc 4a000080
t branch
p 00 24010001
p 04 10200002
p 08 24020002
p 0c 14200002
p 10 24030003
p 14 ac010300
p 18 ac020308
p 1c 10420002
p 20 ac03030c
p 24 ac010310
p 28 14420002
p 2c 24640004
p 30 ac0403fc
e 308 00000002
e 30c 00000003
e 3fc 00000007
